// ==== aes_pkg.sv ====
//////////////////////////////////////////////////
// aes package
// widths, block and word types, round constants
// and the GF(2^8) helpers behind the S-box
//////////////////////////////////////////////////

package aes_pkg;

	// sizes for AES-128, Nk = Nb = 4, Nr = 10
	localparam int block_bits = 128;
	localparam int word_bits = 32;
	localparam int num_rounds = 10;

	// state, key, plaintext or ciphertext
	typedef logic [block_bits-1:0] block_t;
	// one column of the state
	typedef logic [word_bits-1:0] word_t;
	typedef logic [7:0] byte_t;
	// round index 0 to 10
	typedef logic [3:0] round_t;

	// low byte of x^8+x^4+x^3+x+1
	localparam byte_t gf_poly = 8'h1b;

	// rcon[i] = x^(i-1) in the top byte
	localparam word_t rcon_table [1:num_rounds] = '{
		32'h01000000,
		32'h02000000,
		32'h04000000,
		32'h08000000,
		32'h10000000,
		32'h20000000,
		32'h40000000,
		32'h80000000,
		32'h1b000000,
		32'h36000000
	};

	//////////////////////////////////////////////////
	// GF(2^8) arithmetic
	//////////////////////////////////////////////////

	// multiply by x, reduce when bit 7 falls off
	function automatic byte_t gf_xtime(input byte_t a);
		byte_t shifted;
		shifted = {a[6:0], 1'b0};
		return a[7] ? (shifted ^ gf_poly) : shifted;
	endfunction

	// shift-and-add multiply, one partial product per bit of b
	function automatic byte_t gf_mul(input byte_t a, input byte_t b);
		byte_t acc;
		byte_t x;
		acc = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				acc = acc ^ x;
			x = gf_xtime(x);
		end
		return acc;
	endfunction

	//////////////////////////////////////////////////
	// S-box
	//////////////////////////////////////////////////

	// inverse as a^254 = a^2 * a^4 * ... * a^128
	// zero stays zero, so the affine map gives 8'h63
	function automatic byte_t sbox_byte(input byte_t a);
		byte_t inv;
		byte_t p;
		inv = 8'h01;
		p = a;
		for (int i = 1; i < 8; i++) begin
			// p walks through a^2, a^4 .. a^128
			p = gf_mul(p, p);
			inv = gf_mul(inv, p);
		end
		// affine map, the inverse xor its left rotations by 1 to 4
		return inv
			^ {inv[6:0], inv[7]}
			^ {inv[5:0], inv[7:6]}
			^ {inv[4:0], inv[7:5]}
			^ {inv[3:0], inv[7:4]}
			^ 8'h63;
	endfunction

endpackage

// ==== aes_sub_bytes.sv ====
//////////////////////////////////////////////////
// aes_sub_bytes
// byte-wise S-box substitution over a payload
// whose width is a multiple of 8
//////////////////////////////////////////////////

module aes_sub_bytes import aes_pkg::*; #(
	parameter type data_t = block_t
) (
	input  data_t in,
	output data_t out
);

	// number of bytes follows the payload type
	localparam int num_bytes = $bits(data_t) / 8;

	// one combinational S-box per byte
	genvar i;
	generate
		for (i = 0; i < num_bytes; i++) begin : g_byte
			assign out[8*i +: 8] = sbox_byte(in[8*i +: 8]);
		end
	endgenerate

endmodule

// ==== aes_key_expand.sv ====
//////////////////////////////////////////////////
// aes_key_expand
// round key register and the next-round key
// schedule, one round key per cycle
//////////////////////////////////////////////////

module aes_key_expand import aes_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   load_key,
	input  logic   advance,
	input  block_t key,
	input  round_t round,
	output block_t next_key
);

	// key of the round just finished
	block_t round_key;

	// old words, w0 is the top of the block
	word_t w0, w1, w2, w3;
	// new words
	word_t n0, n1, n2, n3;
	word_t rot_w3;
	word_t sub_w3;
	word_t rcon_w;

	assign {w0, w1, w2, w3} = round_key;

	// RotWord, top byte moves to the bottom
	assign rot_w3 = {w3[23:0], w3[31:24]};

	// SubWord on the rotated word
	aes_sub_bytes #(.data_t(word_t)) sub_word0 (
		.in  (rot_w3),
		.out (sub_w3)
	);

	// rcon lookup, only rounds 1 to 10 have an entry
	always_comb begin
		if (round >= 4'd1 && round <= round_t'(num_rounds))
			rcon_w = rcon_table[round];
		else
			rcon_w = '0;
	end

	// each later word chains off the new word before it
	assign n0 = w0 ^ sub_w3 ^ rcon_w;
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;
	assign next_key = {n0, n1, n2, n3};

	// cipher key on load, then step once per round
	always_ff @(posedge clk) begin
		if (reset)
			round_key <= '0;
		else if (load_key)
			round_key <= key;
		else if (advance)
			round_key <= next_key;
	end

endmodule

// ==== aes_round.sv ====
//////////////////////////////////////////////////
// aes_round
// cipher state register with SubBytes,
// ShiftRows, MixColumns and AddRoundKey
//////////////////////////////////////////////////

module aes_round import aes_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   load_state,
	input  logic   advance,
	input  logic   final_round,
	input  block_t plaintext,
	input  block_t key,
	input  block_t round_key,
	output block_t state
);

	block_t sub_state;
	block_t shifted;
	block_t mixed;
	block_t result;

	// SubBytes over all 16 bytes
	aes_sub_bytes #(.data_t(block_t)) sub_state0 (
		.in  (state),
		.out (sub_state)
	);

	// ShiftRows
	// S[r][c] sits at bits 127-8*(4c+r), row r rotates left by r
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[127 - 8*(4*c + r) -: 8] =
					sub_state[127 - 8*(4*((c + r) % 4) + r) -: 8];
			end
		end
	end

	// MixColumns
	// y_i = a_i ^ t ^ 2*(a_i ^ a_i+1), t = xor of the column
	always_comb begin
		byte_t a0, a1, a2, a3;
		byte_t t;
		for (int c = 0; c < 4; c++) begin
			{a0, a1, a2, a3} = shifted[127 - 32*c -: 32];
			t = a0 ^ a1 ^ a2 ^ a3;
			mixed[127 - 32*c -: 32] = {
				a0 ^ t ^ gf_xtime(a0 ^ a1),
				a1 ^ t ^ gf_xtime(a1 ^ a2),
				a2 ^ t ^ gf_xtime(a2 ^ a3),
				a3 ^ t ^ gf_xtime(a3 ^ a0)
			};
		end
	end

	// last round has no MixColumns
	// AddRoundKey with the key being produced this cycle
	assign result = (final_round ? shifted : mixed) ^ round_key;

	// initial AddRoundKey on load, one round per cycle after
	always_ff @(posedge clk) begin
		if (reset)
			state <= '0;
		else if (load_state)
			state <= plaintext ^ key;
		else if (advance)
			state <= result;
	end

endmodule

// ==== aes_core.sv ====
//////////////////////////////////////////////////
// aes_core
// round counter, start and done control around
// the key schedule and the round datapath
//////////////////////////////////////////////////

module aes_core import aes_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  logic   clear,
	input  block_t plaintext,
	input  block_t key,
	output block_t ciphertext,
	output logic   done
);

	// round being computed, 1 to 10 while busy
	round_t round;
	logic busy;
	logic final_round;
	// round key shared by the schedule and the state update
	block_t next_key;

	assign final_round = (round == round_t'(num_rounds));

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////

	// start wins over everything, so a new run restarts a busy one
	// clear drops done and abandons a run in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			round <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else if (start) begin
			round <= 4'd1;
			busy <= 1'b1;
			done <= 1'b0;
		end else if (clear) begin
			round <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else if (busy) begin
			if (final_round) begin
				// round 10 is written at this edge
				round <= '0;
				busy <= 1'b0;
				done <= 1'b1;
			end else begin
				round <= round + 4'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	aes_key_expand key_expand0 (
		.clk      (clk),
		.reset    (reset),
		.load_key (start),
		.advance  (busy),
		.key      (key),
		.round    (round),
		.next_key (next_key)
	);

	// state after round 10 is the ciphertext
	aes_round round0 (
		.clk         (clk),
		.reset       (reset),
		.load_state  (start),
		.advance     (busy),
		.final_round (final_round),
		.plaintext   (plaintext),
		.key         (key),
		.round_key   (next_key),
		.state       (ciphertext)
	);

endmodule

// ==== aes_spi_in.sv ====
//////////////////////////////////////////////////
// aes_spi_in
// serial input side, brings sck, sdi and load
// into clk and shifts in plaintext then key
//////////////////////////////////////////////////

module aes_spi_in import aes_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   sck,
	input  logic   sdi,
	input  logic   load,
	output logic   sck_fall,
	output logic   start,
	output logic   clear,
	output block_t plaintext,
	output block_t key
);

	// two sync flops plus one more for edge detect
	logic [2:0] sck_sync;
	logic [2:0] load_sync;
	// sdi only needs the two sync flops, it lines up with sck_sync[1]
	logic [1:0] sdi_sync;
	logic sck_rise;

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync <= '0;
			load_sync <= '0;
			sdi_sync <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
			load_sync <= {load_sync[1:0], load};
			sdi_sync <= {sdi_sync[0], sdi};
		end
	end

	// edge pulses, one clk cycle each
	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];
	assign start = ~load_sync[1] & load_sync[2];
	assign clear = load_sync[1] & ~load_sync[2];

	// 256-bit shift register, plaintext over key
	// msb first, so the first bit ends up at plaintext[127]
	always_ff @(posedge clk) begin
		if (sck_rise && load_sync[1])
			{plaintext, key} <= {plaintext[126:0], key, sdi_sync[1]};
	end

endmodule

// ==== aes_spi_out.sv ====
//////////////////////////////////////////////////
// aes_spi_out
// captures the ciphertext when done rises and
// shifts it out msb first on falling sck
//////////////////////////////////////////////////

module aes_spi_out import aes_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  block_t ciphertext,
	input  logic   done,
	input  logic   sck_fall,
	output logic   sdo
);

	// done from the previous cycle
	logic done_q;
	logic done_rise;
	// top bit drives sdo once captured
	block_t out_shift;

	assign done_rise = done & ~done_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			done_q <= 1'b0;
			out_shift <= '0;
		end else begin
			done_q <= done;
			if (done_rise)
				out_shift <= ciphertext;
			else if (sck_fall)
				// next bit onto sdo, host samples before rising sck
				out_shift <= {out_shift[126:0], 1'b0};
		end
	end

	// bit 127 shows straight away in the capture cycle
	assign sdo = done_rise ? ciphertext[127] : out_shift[127];

endmodule

// ==== aes_top.sv ====
//////////////////////////////////////////////////
// aes_top
// AES-128 encryption behind a serial port
//////////////////////////////////////////////////

module aes_top import aes_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic sck,
	input  logic sdi,
	input  logic load,
	output logic sdo,
	output logic done
);

	logic sck_fall;
	logic start;
	logic clear;
	block_t plaintext;
	block_t key;
	block_t ciphertext;

	// serial in, plaintext then key
	aes_spi_in spi_in0 (
		.clk       (clk),
		.reset     (reset),
		.sck       (sck),
		.sdi       (sdi),
		.load      (load),
		.sck_fall  (sck_fall),
		.start     (start),
		.clear     (clear),
		.plaintext (plaintext),
		.key       (key)
	);

	aes_core core0 (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.clear      (clear),
		.plaintext  (plaintext),
		.key        (key),
		.ciphertext (ciphertext),
		.done       (done)
	);

	// serial out of the ciphertext
	aes_spi_out spi_out0 (
		.clk        (clk),
		.reset      (reset),
		.ciphertext (ciphertext),
		.done       (done),
		.sck_fall   (sck_fall),
		.sdo        (sdo)
	);

endmodule

// ==== tb_aes.sv ====
//////////////////////////////////////////////////
// tb_aes
// directed testbench for the serial AES-128 core
//////////////////////////////////////////////////

module tb_aes import aes_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	// sck half period in clk cycles
	localparam int half_period = 4;
	// done must follow the fall of load within this many cycles
	localparam int done_limit = 20;
	// four runs of about 3500 cycles each, plus reset and margin
	localparam int timeout_cycles = 20000;

	// FIPS-197 appendix C.1
	localparam block_t key_c1 = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t pt_c1 = 128'h00112233445566778899aabbccddeeff;
	localparam block_t ct_c1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	// FIPS-197 appendix B
	localparam block_t key_b = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam block_t pt_b = 128'h3243f6a8885a308d313198a2e0370734;
	localparam block_t ct_b = 128'h3925841d02dc09fbdc118597196a0b32;

	logic clk;
	logic reset;
	logic sck;
	logic sdi;
	logic load;
	logic sdo;
	logic done;

	int errors;
	int checks;
	int cycle_count;

	aes_top dut0 (
		.clk   (clk),
		.reset (reset),
		.sck   (sck),
		.sdi   (sdi),
		.load  (load),
		.sdo   (sdo),
		.done  (done)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// leaves the caller 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check_block(input block_t got, input block_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_done(input logic got, input logic exp, input string msg);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
			errors++;
		end
	endtask

	// plaintext then key, msb first, sdi changes with falling sck
	task automatic spi_load(input block_t pt, input block_t k);
		logic [255:0] bits;
		bits = {pt, k};
		load = 1'b1;
		for (int i = 255; i >= 0; i--) begin
			sdi = bits[i];
			sck = 1'b0;
			wait_cycles(half_period);
			// first check lands before the first rising sck
			if (i == 255)
				check_done(done, 1'b0, "done cleared by load");
			else
				check_done(done, 1'b0, "done during shift in");
			sck = 1'b1;
			wait_cycles(half_period);
		end
		sck = 1'b0;
		wait_cycles(half_period);
		load = 1'b0;
	endtask

	// bounded wait, called right after load falls
	task automatic wait_for_done();
		int n;
		n = 0;
		while (done !== 1'b1 && n < done_limit) begin
			wait_cycles(1);
			n++;
		end
		if (done !== 1'b1) begin
			$display("done did not rise within %0d clk cycles after load fell", done_limit);
			errors++;
		end
	endtask

	// sdo is sampled at the end of each low phase of sck
	task automatic spi_read(output block_t data);
		data = '0;
		for (int i = 127; i >= 0; i--) begin
			sck = 1'b0;
			wait_cycles(half_period);
			data[i] = sdo;
			sck = 1'b1;
			wait_cycles(half_period);
		end
		sck = 1'b0;
		wait_cycles(half_period);
	endtask

	// one full encryption through the serial ports
	task automatic run_vector(input block_t pt, input block_t k, input block_t exp,
			input string name);
		block_t ct;
		spi_load(pt, k);
		wait_for_done();
		spi_read(ct);
		check_block(ct, exp, name);
		// done holds until the next load
		check_done(done, 1'b1, "done after read");
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		check_done(done, 1'b0, "done after reset");
	endtask

	// full datapath and final-round bypass
	task automatic test_fips_vector();
		run_vector(pt_c1, key_c1, ct_c1, "appendix C.1 ciphertext");
	endtask

	// key schedule and rcon, starts with done still high
	task automatic test_appendix_b();
		run_vector(pt_b, key_b, ct_b, "appendix B ciphertext");
	endtask

	// no reset between runs, nothing may carry over
	task automatic test_back_to_back();
		run_vector(pt_b, key_b, ct_b, "back to back first run");
		run_vector(pt_c1, key_c1, ct_c1, "back to back second run");
	endtask

	// run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout, the run did not end within %0d clk cycles", timeout_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		errors = 0;
		checks = 0;
		reset = 1'b1;
		sck = 1'b0;
		sdi = 1'b0;
		load = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		wait_cycles(2);

		test_reset_state();
		test_fips_vector();
		test_appendix_b();
		test_back_to_back();

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
aes_pkg.sv
aes_sub_bytes.sv
aes_key_expand.sv
aes_round.sv
aes_core.sv
aes_spi_in.sv
aes_spi_out.sv
aes_top.sv
tb_aes.sv
